/* tb.f */
+incdir+tb
src/exu_pkg.sv
src/exu_wb_fifo.sv
src/exu_alu_lane.sv
src/exu_bru.sv
src/exu_csr_regs.sv
src/exu_top.sv
tb/exu_tb.sv

/* tb/exu_model.svh */
// reference model for exu_tb; include inside a module that imports exu_pkg and sets MTVEC_RESET
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

localparam int Q_ALU0 = 0;
localparam int Q_ALU1 = 1;
localparam int Q_CSR  = 2;

// expected writebacks per path in arrival order
wb_t   exp_q[3][$];
data_t m_last0    = '0;
data_t m_last1    = '0;
data_t m_mtvec    = MTVEC_RESET;
data_t m_mepc     = '0;
data_t m_mscratch = '0;

function automatic data_t pick_operand(operand_src_e src, data_t given);
    if (src == SRC_LANE0)
        return m_last0;
    if (src == SRC_LANE1)
        return m_last1;
    return given;
endfunction

function automatic data_t alu_result(alu_op_e op, data_t a, data_t b);
    int    sh;
    data_t fill;
    sh = int'(b & 32'h1f);
    // sign bits shifted in by an arithmetic right shift
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'd0;
    case (op)
        ADD:     return a + b;
        SUB:     return a + ~b + 32'd1;
        SLL:     return a << sh;
        SLT:     return data_t'((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000));
        SLTU:    return data_t'(a < b);
        XOR:     return a ^ b;
        SRL:     return a >> sh;
        SRA:     return (a >> sh) | fill;
        OR:      return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(bjp_op_e op, data_t a, data_t b);
    logic lt_s;
    lt_s = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    case (op)
        BEQ:     return a == b;
        BNE:     return a != b;
        BLT:     return lt_s;
        BLTU:    return a < b;
        BGE:     return !lt_s;
        BGEU:    return !(a < b);
        default: return 1'b1;
    endcase
endfunction

function automatic data_t branch_target(bjp_op_e op, data_t j1, data_t j2);
    data_t t;
    t = j1 + j2;
    if (op == JALR)
        t[0] = 1'b0;
    return t;
endfunction

function automatic data_t csr_value(csr_addr_t addr);
    case (addr)
        CSR_MTVEC:    return m_mtvec;
        CSR_MEPC:     return m_mepc;
        CSR_MSCRATCH: return m_mscratch;
        default:      return 32'd0;
    endcase
endfunction

task automatic update_csrs(input logic accept, input csr_op_e op, input csr_addr_t addr,
                           input data_t op1, input logic ecall, input data_t pc);
    data_t nv;
    nv = csr_value(addr);
    case (op)
        CSRRW:   nv = op1;
        CSRRS:   nv = nv | op1;
        default: nv = nv & ~op1;
    endcase
    if (accept && (op == CSRRW || op1 != 32'd0)) begin
        case (addr)
            CSR_MTVEC:    m_mtvec = nv;
            CSR_MEPC:     m_mepc = nv;
            CSR_MSCRATCH: m_mscratch = nv;
            default:      ;
        endcase
    end
    // trap entry beats a same-cycle software write
    if (ecall)
        m_mepc = pc;
endtask

`endif

/* tb/exu_tb.sv */
// self-checking testbench for exu_top with WB_DEPTH 2; stops at the first mismatch
`timescale 1ns/1ns

module exu_tb;
    import exu_pkg::*;

    localparam int    WB_DEPTH       = 2;
    localparam data_t MTVEC_RESET    = 32'h0000_0100;
    localparam int    CLK_PERIOD     = 4;
    localparam int    RESET_CYCLES   = 16;
    localparam int    RANDOM_CYCLES  = 400;
    localparam int    STALL_CYCLES   = 12;
    localparam int    NUM_OPS        = 2 * RANDOM_CYCLES + STALL_CYCLES;
    localparam int    OP_CYCLE_BOUND = 2;
    localparam int    MODE_RANDOM    = 0;
    localparam int    MODE_STALL     = 1;
    localparam int    MODE_DRAIN     = 2;

    logic         clk;
    logic         arst_n_i;
    logic         alu0_valid_i, alu0_reg_we_i, alu0_ready_o, alu0_wb_ready_i;
    logic         alu0_wb_valid_o, alu0_wb_we_o;
    alu_op_e      alu0_op_i;
    data_t        alu0_op1_i, alu0_op2_i, alu0_wb_data_o;
    operand_src_e alu0_op1_src_i, alu0_op2_src_i;
    reg_addr_t    alu0_rd_i, alu0_wb_rd_o;
    commit_id_t   alu0_commit_id_i, alu0_wb_commit_id_o;
    logic         alu1_valid_i, alu1_reg_we_i, alu1_ready_o, alu1_wb_ready_i;
    logic         alu1_wb_valid_o, alu1_wb_we_o;
    alu_op_e      alu1_op_i;
    data_t        alu1_op1_i, alu1_op2_i, alu1_wb_data_o;
    operand_src_e alu1_op1_src_i, alu1_op2_src_i;
    reg_addr_t    alu1_rd_i, alu1_wb_rd_o;
    commit_id_t   alu1_commit_id_i, alu1_wb_commit_id_o;
    logic         csr_valid_i, csr_ready_o, csr_wb_ready_i, csr_wb_valid_o, csr_wb_we_o;
    csr_op_e      csr_op_i;
    csr_addr_t    csr_addr_i;
    data_t        csr_op1_i, csr_wb_data_o;
    reg_addr_t    csr_rd_i, csr_wb_rd_o;
    commit_id_t   csr_commit_id_i, csr_wb_commit_id_o;
    logic         bjp_valid_i, ecall_i, mret_i, jump_flag_o, misaligned_fetch_o;
    bjp_op_e      bjp_op_i;
    data_t        bjp_op1_i, bjp_op2_i, bjp_jump_op1_i, bjp_jump_op2_i, pc_i, jump_addr_o;
    integer       seed = 35855;

    `include "exu_model.svh"

    exu_top #(
        .WB_DEPTH   (WB_DEPTH),
        .MTVEC_RESET(MTVEC_RESET)
    ) DUT (
        .*
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic int unsigned rand_below(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("[ERROR] %s expected %h got %h", name, exp, act));
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp)
            fail_run({$sformatf("[ERROR] %s expected we=%h rd=%h data=%h id=%h", name,
                                exp.we, exp.rd, exp.data, exp.commit_id),
                      $sformatf(" got we=%h rd=%h data=%h id=%h",
                                act.we, act.rd, act.data, act.commit_id)});
    endtask

    task automatic check_redirect(input logic exp_flag, input data_t exp_addr, input logic exp_mis,
                                  input logic act_flag, input data_t act_addr, input logic act_mis);
        check_flag("jump_flag_o", exp_flag, act_flag);
        check_flag("misaligned_fetch_o", exp_mis, act_mis);
        // target only matters when a redirect is taken
        if (exp_flag && act_addr !== exp_addr)
            fail_run($sformatf("[ERROR] jump_addr_o expected %h got %h", exp_addr, act_addr));
    endtask

    task automatic make_alu_req(input int mode, output logic valid, output alu_op_e op,
                                output data_t op1, output data_t op2,
                                output operand_src_e src1, output operand_src_e src2,
                                output reg_addr_t rd, output logic we, output commit_id_t cid);
        valid = (mode == MODE_STALL) || ((mode == MODE_RANDOM) && rand_below(4) != 0);
        op    = alu_op_e'(rand_below(10));
        op1   = data_t'($random(seed));
        // small values exercise shift amounts and compares near zero
        op2   = rand_below(2) ? data_t'(rand_below(40)) : data_t'($random(seed));
        src1  = operand_src_e'(rand_below(3));
        src2  = operand_src_e'(rand_below(3));
        rd    = reg_addr_t'(rand_below(32));
        we    = rand_below(4) != 0;
        cid   = commit_id_t'(rand_below(8));
    endtask

    task automatic drive_inputs(input int mode);
        make_alu_req(mode, alu0_valid_i, alu0_op_i, alu0_op1_i, alu0_op2_i, alu0_op1_src_i,
                     alu0_op2_src_i, alu0_rd_i, alu0_reg_we_i, alu0_commit_id_i);
        make_alu_req(mode, alu1_valid_i, alu1_op_i, alu1_op1_i, alu1_op2_i, alu1_op1_src_i,
                     alu1_op2_src_i, alu1_rd_i, alu1_reg_we_i, alu1_commit_id_i);
        csr_valid_i = (mode == MODE_STALL) || ((mode == MODE_RANDOM) && rand_below(3) == 0);
        csr_op_i    = csr_op_e'(1 + rand_below(3));
        case (rand_below(4))
            0:       csr_addr_i = CSR_MTVEC;
            1:       csr_addr_i = CSR_MEPC;
            2:       csr_addr_i = CSR_MSCRATCH;
            default: csr_addr_i = 12'h7c0;
        endcase
        csr_op1_i       = (rand_below(4) == 0) ? 32'd0 : data_t'($random(seed));
        csr_rd_i        = reg_addr_t'(rand_below(32));
        csr_commit_id_i = commit_id_t'(rand_below(8));
        // back-pressure from the writeback stage
        alu0_wb_ready_i = (mode == MODE_DRAIN) || ((mode == MODE_RANDOM) && rand_below(2) != 0);
        alu1_wb_ready_i = (mode == MODE_DRAIN) || ((mode == MODE_RANDOM) && rand_below(2) != 0);
        csr_wb_ready_i  = (mode == MODE_DRAIN) || ((mode == MODE_RANDOM) && rand_below(2) != 0);
        bjp_valid_i    = rand_below(2);
        bjp_op_i       = bjp_op_e'(rand_below(8));
        bjp_op1_i      = data_t'($random(seed));
        bjp_op2_i      = (rand_below(4) == 0) ? bjp_op1_i : data_t'($random(seed));
        bjp_jump_op1_i = data_t'($random(seed));
        bjp_jump_op2_i = data_t'($random(seed));
        pc_i           = data_t'($random(seed));
        ecall_i        = rand_below(16) == 0;
        mret_i         = rand_below(16) == 0;
    endtask

    task automatic init_inputs();
        arst_n_i = 1'b0;
        drive_inputs(MODE_DRAIN);
        alu0_valid_i = 1'b0;
        alu1_valid_i = 1'b0;
        csr_valid_i  = 1'b0;
        bjp_valid_i  = 1'b0;
        ecall_i      = 1'b0;
        mret_i       = 1'b0;
    endtask

    // compare one path, then pop and push as the edge will
    task automatic step_queue(input int idx, input string name, input logic valid,
                              input logic ready, input logic wb_valid, input logic wb_ready,
                              input wb_t act, input wb_t pushed);
        logic exp_ready;
        exp_ready = exp_q[idx].size() < WB_DEPTH;
        check_flag({name, "_ready_o"}, exp_ready, ready);
        check_flag({name, "_wb_valid_o"}, exp_q[idx].size() != 0, wb_valid);
        if (wb_valid) begin
            check_wb({name, "_wb"}, exp_q[idx][0], act);
            if (wb_ready)
                void'(exp_q[idx].pop_front());
        end
        if (valid && exp_ready)
            exp_q[idx].push_back(pushed);
    endtask

    task automatic score_cycle();
        logic  taken;
        data_t target;
        data_t res0;
        data_t res1;
        logic  acc0;
        logic  acc1;
        logic  acc_csr;
        taken  = bjp_valid_i && branch_taken(bjp_op_i, bjp_op1_i, bjp_op2_i);
        target = branch_target(bjp_op_i, bjp_jump_op1_i, bjp_jump_op2_i);
        // trap target wins and ecall beats mret
        if (ecall_i || mret_i)
            check_redirect(1'b1, ecall_i ? m_mtvec : m_mepc, 1'b0,
                           jump_flag_o, jump_addr_o, misaligned_fetch_o);
        else
            check_redirect(taken, target, taken & target[1],
                           jump_flag_o, jump_addr_o, misaligned_fetch_o);
        // both lanes see the last results held before this edge
        res0 = alu_result(alu0_op_i, pick_operand(alu0_op1_src_i, alu0_op1_i),
                          pick_operand(alu0_op2_src_i, alu0_op2_i));
        res1 = alu_result(alu1_op_i, pick_operand(alu1_op1_src_i, alu1_op1_i),
                          pick_operand(alu1_op2_src_i, alu1_op2_i));
        acc0    = alu0_valid_i && exp_q[Q_ALU0].size() < WB_DEPTH;
        acc1    = alu1_valid_i && exp_q[Q_ALU1].size() < WB_DEPTH;
        acc_csr = csr_valid_i && exp_q[Q_CSR].size() < WB_DEPTH;
        step_queue(Q_ALU0, "alu0", alu0_valid_i, alu0_ready_o, alu0_wb_valid_o, alu0_wb_ready_i,
                   {alu0_wb_we_o, alu0_wb_rd_o, alu0_wb_data_o, alu0_wb_commit_id_o},
                   {alu0_reg_we_i, alu0_rd_i, res0, alu0_commit_id_i});
        step_queue(Q_ALU1, "alu1", alu1_valid_i, alu1_ready_o, alu1_wb_valid_o, alu1_wb_ready_i,
                   {alu1_wb_we_o, alu1_wb_rd_o, alu1_wb_data_o, alu1_wb_commit_id_o},
                   {alu1_reg_we_i, alu1_rd_i, res1, alu1_commit_id_i});
        step_queue(Q_CSR, "csr", csr_valid_i, csr_ready_o, csr_wb_valid_o, csr_wb_ready_i,
                   {csr_wb_we_o, csr_wb_rd_o, csr_wb_data_o, csr_wb_commit_id_o},
                   {1'b1, csr_rd_i, csr_value(csr_addr_i), csr_commit_id_i});
        if (acc0)
            m_last0 = res0;
        if (acc1)
            m_last1 = res1;
        update_csrs(acc_csr, csr_op_i, csr_addr_i, csr_op1_i, ecall_i, pc_i);
    endtask

    // drive on the falling edge, sample a nanosecond before the rising edge
    task automatic run_cycle(input int mode);
        @(negedge clk);
        drive_inputs(mode);
        #1;
        score_cycle();
    endtask

    initial begin
        init_inputs();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        check_flag("alu0_wb_valid_o", 1'b0, alu0_wb_valid_o);
        check_flag("alu1_wb_valid_o", 1'b0, alu1_wb_valid_o);
        check_flag("csr_wb_valid_o", 1'b0, csr_wb_valid_o);
        arst_n_i = 1'b1;
        repeat (RANDOM_CYCLES) run_cycle(MODE_RANDOM);
        // ready must drop after WB_DEPTH accepts while wb_ready is held low
        repeat (STALL_CYCLES) run_cycle(MODE_STALL);
        repeat (RANDOM_CYCLES) run_cycle(MODE_RANDOM);
        while (exp_q[Q_ALU0].size() + exp_q[Q_ALU1].size() + exp_q[Q_CSR].size() != 0)
            run_cycle(MODE_DRAIN);
        // one idle cycle confirms nothing extra comes out
        run_cycle(MODE_DRAIN);
        $display("TEST PASS");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + NUM_OPS * OP_CYCLE_BOUND) * CLK_PERIOD);
        fail_run("run timed out before all writebacks drained");
    end

endmodule

/* src/exu_top.sv */
// dual-issue exu without mul/div/lsu; trap redirect wins over a taken branch in the same cycle
`timescale 1ns/1ns

module exu_top #(
    parameter int             WB_DEPTH    = 2,
    parameter exu_pkg::data_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    // lane 0
    input  logic                  alu0_valid_i,
    input  exu_pkg::alu_op_e      alu0_op_i,
    input  exu_pkg::data_t        alu0_op1_i,
    input  exu_pkg::data_t        alu0_op2_i,
    input  exu_pkg::operand_src_e alu0_op1_src_i,
    input  exu_pkg::operand_src_e alu0_op2_src_i,
    input  exu_pkg::reg_addr_t    alu0_rd_i,
    input  logic                  alu0_reg_we_i,
    input  exu_pkg::commit_id_t   alu0_commit_id_i,
    output logic                  alu0_ready_o,
    output logic                  alu0_wb_valid_o,
    output logic                  alu0_wb_we_o,
    output exu_pkg::reg_addr_t    alu0_wb_rd_o,
    output exu_pkg::data_t        alu0_wb_data_o,
    output exu_pkg::commit_id_t   alu0_wb_commit_id_o,
    input  logic                  alu0_wb_ready_i,
    // lane 1
    input  logic                  alu1_valid_i,
    input  exu_pkg::alu_op_e      alu1_op_i,
    input  exu_pkg::data_t        alu1_op1_i,
    input  exu_pkg::data_t        alu1_op2_i,
    input  exu_pkg::operand_src_e alu1_op1_src_i,
    input  exu_pkg::operand_src_e alu1_op2_src_i,
    input  exu_pkg::reg_addr_t    alu1_rd_i,
    input  logic                  alu1_reg_we_i,
    input  exu_pkg::commit_id_t   alu1_commit_id_i,
    output logic                  alu1_ready_o,
    output logic                  alu1_wb_valid_o,
    output logic                  alu1_wb_we_o,
    output exu_pkg::reg_addr_t    alu1_wb_rd_o,
    output exu_pkg::data_t        alu1_wb_data_o,
    output exu_pkg::commit_id_t   alu1_wb_commit_id_o,
    input  logic                  alu1_wb_ready_i,
    // csr access
    input  logic                  csr_valid_i,
    input  exu_pkg::csr_op_e      csr_op_i,
    input  exu_pkg::csr_addr_t    csr_addr_i,
    input  exu_pkg::data_t        csr_op1_i,
    input  exu_pkg::reg_addr_t    csr_rd_i,
    input  exu_pkg::commit_id_t   csr_commit_id_i,
    output logic                  csr_ready_o,
    input  logic                  csr_wb_ready_i,
    output logic                  csr_wb_valid_o,
    output logic                  csr_wb_we_o,
    output exu_pkg::reg_addr_t    csr_wb_rd_o,
    output exu_pkg::data_t        csr_wb_data_o,
    output exu_pkg::commit_id_t   csr_wb_commit_id_o,
    // branch and system ops
    input  logic                  bjp_valid_i,
    input  exu_pkg::bjp_op_e      bjp_op_i,
    input  exu_pkg::data_t        bjp_op1_i,
    input  exu_pkg::data_t        bjp_op2_i,
    input  exu_pkg::data_t        bjp_jump_op1_i,
    input  exu_pkg::data_t        bjp_jump_op2_i,
    input  exu_pkg::data_t        pc_i,
    input  logic                  ecall_i,
    input  logic                  mret_i,
    output logic                  jump_flag_o,
    output exu_pkg::data_t        jump_addr_o,
    output logic                  misaligned_fetch_o
);
    import exu_pkg::*;

    data_t alu0_last;
    data_t alu1_last;
    logic  bru_taken;
    data_t bru_target;
    logic  bru_misaligned;
    logic  trap_valid;
    data_t trap_target;

    // both lanes get the same last-result pair, in lane order
    exu_alu_lane #(
        .WB_DEPTH(WB_DEPTH)
    ) u_alu0 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (alu0_valid_i),
        .op_i          (alu0_op_i),
        .op1_i         (alu0_op1_i),
        .op2_i         (alu0_op2_i),
        .op1_src_i     (alu0_op1_src_i),
        .op2_src_i     (alu0_op2_src_i),
        .rd_i          (alu0_rd_i),
        .reg_we_i      (alu0_reg_we_i),
        .commit_id_i   (alu0_commit_id_i),
        .lane0_last_i  (alu0_last),
        .lane1_last_i  (alu1_last),
        .ready_o       (alu0_ready_o),
        .last_result_o (alu0_last),
        .wb_valid_o    (alu0_wb_valid_o),
        .wb_we_o       (alu0_wb_we_o),
        .wb_rd_o       (alu0_wb_rd_o),
        .wb_data_o     (alu0_wb_data_o),
        .wb_commit_id_o(alu0_wb_commit_id_o),
        .wb_ready_i    (alu0_wb_ready_i)
    );

    exu_alu_lane #(
        .WB_DEPTH(WB_DEPTH)
    ) u_alu1 (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .valid_i       (alu1_valid_i),
        .op_i          (alu1_op_i),
        .op1_i         (alu1_op1_i),
        .op2_i         (alu1_op2_i),
        .op1_src_i     (alu1_op1_src_i),
        .op2_src_i     (alu1_op2_src_i),
        .rd_i          (alu1_rd_i),
        .reg_we_i      (alu1_reg_we_i),
        .commit_id_i   (alu1_commit_id_i),
        .lane0_last_i  (alu0_last),
        .lane1_last_i  (alu1_last),
        .ready_o       (alu1_ready_o),
        .last_result_o (alu1_last),
        .wb_valid_o    (alu1_wb_valid_o),
        .wb_we_o       (alu1_wb_we_o),
        .wb_rd_o       (alu1_wb_rd_o),
        .wb_data_o     (alu1_wb_data_o),
        .wb_commit_id_o(alu1_wb_commit_id_o),
        .wb_ready_i    (alu1_wb_ready_i)
    );

    // port names match the top level, only the outputs are renamed
    exu_bru u_bru (
        .taken_o           (bru_taken),
        .target_o          (bru_target),
        .misaligned_fetch_o(bru_misaligned),
        .*
    );

    exu_csr_regs #(
        .WB_DEPTH   (WB_DEPTH),
        .MTVEC_RESET(MTVEC_RESET)
    ) u_csr (
        .trap_valid_o (trap_valid),
        .trap_target_o(trap_target),
        .*
    );

    // redirect merge, trap target first
    assign jump_flag_o        = trap_valid | bru_taken;
    assign jump_addr_o        = trap_valid ? trap_target : bru_target;
    assign misaligned_fetch_o = bru_misaligned & ~trap_valid;

endmodule

/* src/exu_csr_regs.sv */
// machine CSRs mtvec, mepc, mscratch only; other addresses read zero, ecall beats mret
`timescale 1ns/1ns

module exu_csr_regs #(
    parameter int             WB_DEPTH    = 2,
    parameter exu_pkg::data_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                csr_valid_i,
    input  exu_pkg::csr_op_e    csr_op_i,
    input  exu_pkg::csr_addr_t  csr_addr_i,
    input  exu_pkg::data_t      csr_op1_i,
    input  exu_pkg::reg_addr_t  csr_rd_i,
    input  exu_pkg::commit_id_t csr_commit_id_i,
    output logic                csr_ready_o,
    input  logic                csr_wb_ready_i,
    output logic                csr_wb_valid_o,
    output logic                csr_wb_we_o,
    output exu_pkg::reg_addr_t  csr_wb_rd_o,
    output exu_pkg::data_t      csr_wb_data_o,
    output exu_pkg::commit_id_t csr_wb_commit_id_o,
    input  exu_pkg::data_t      pc_i,
    input  logic                ecall_i,
    input  logic                mret_i,
    output logic                trap_valid_o,
    output exu_pkg::data_t      trap_target_o
);
    import exu_pkg::*;

    data_t mtvec;
    data_t mepc;
    data_t mscratch;
    data_t csr_rdata;
    data_t csr_wdata;
    logic  addr_hit;
    logic  csr_accept;
    logic  csr_wr;
    logic  fifo_full;
    wb_t   push_rec;
    wb_t   pop_rec;

    always_comb begin
        addr_hit = 1'b1;
        case (csr_addr_i)
            CSR_MTVEC:    csr_rdata = mtvec;
            CSR_MEPC:     csr_rdata = mepc;
            CSR_MSCRATCH: csr_rdata = mscratch;
            default: begin
                csr_rdata = '0;
                addr_hit  = 1'b0;
            end
        endcase
    end

    always_comb begin
        case (csr_op_i)
            CSRRW:   csr_wdata = csr_op1_i;
            CSRRS:   csr_wdata = csr_rdata | csr_op1_i;
            CSRRC:   csr_wdata = csr_rdata & ~csr_op1_i;
            default: csr_wdata = csr_rdata;
        endcase
    end

    assign csr_ready_o = ~fifo_full;
    assign csr_accept  = csr_valid_i & csr_ready_o;
    // set and clear with a zero mask leave the register alone
    assign csr_wr = csr_accept & addr_hit & ((csr_op_i == CSRRW) | (csr_op1_i != '0));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtvec    <= MTVEC_RESET;
            mepc     <= '0;
            mscratch <= '0;
        end else begin
            if (csr_wr && (csr_addr_i == CSR_MTVEC))
                mtvec <= csr_wdata;
            if (csr_wr && (csr_addr_i == CSR_MSCRATCH))
                mscratch <= csr_wdata;
            // trap entry overrides a same-cycle software write to mepc
            if (ecall_i)
                mepc <= pc_i;
            else if (csr_wr && (csr_addr_i == CSR_MEPC))
                mepc <= csr_wdata;
        end
    end

    assign trap_valid_o  = ecall_i | mret_i;
    assign trap_target_o = ecall_i ? mtvec : mepc;

    // the old value goes back to rd
    assign push_rec = '{we: 1'b1, rd: csr_rd_i, data: csr_rdata, commit_id: csr_commit_id_i};

    exu_wb_fifo #(
        .WB_DEPTH(WB_DEPTH)
    ) u_wb_fifo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .push_i     (csr_accept),
        .push_data_i(push_rec),
        .pop_ready_i(csr_wb_ready_i),
        .full_o     (fifo_full),
        .pop_valid_o(csr_wb_valid_o),
        .pop_data_o (pop_rec)
    );

    assign csr_wb_we_o        = pop_rec.we;
    assign csr_wb_rd_o        = pop_rec.rd;
    assign csr_wb_data_o      = pop_rec.data;
    assign csr_wb_commit_id_o = pop_rec.commit_id;

endmodule

/* src/exu_bru.sv */
// combinational branch unit; no prediction, taken_o is low without bjp_valid_i
`timescale 1ns/1ns

module exu_bru (
    input  logic             bjp_valid_i,
    input  exu_pkg::bjp_op_e bjp_op_i,
    input  exu_pkg::data_t   bjp_op1_i,
    input  exu_pkg::data_t   bjp_op2_i,
    input  exu_pkg::data_t   bjp_jump_op1_i,
    input  exu_pkg::data_t   bjp_jump_op2_i,
    output logic             taken_o,
    output exu_pkg::data_t   target_o,
    output logic             misaligned_fetch_o
);
    import exu_pkg::*;

    logic  cond;
    data_t sum;

    always_comb begin
        case (bjp_op_i)
            JAL,
            JALR:    cond = 1'b1;
            BEQ:     cond = (bjp_op1_i == bjp_op2_i);
            BNE:     cond = (bjp_op1_i != bjp_op2_i);
            BLT:     cond = ($signed(bjp_op1_i) < $signed(bjp_op2_i));
            BLTU:    cond = (bjp_op1_i < bjp_op2_i);
            BGE:     cond = ($signed(bjp_op1_i) >= $signed(bjp_op2_i));
            BGEU:    cond = (bjp_op1_i >= bjp_op2_i);
            default: cond = 1'b0;
        endcase
    end

    assign taken_o = bjp_valid_i & cond;
    assign sum     = bjp_jump_op1_i + bjp_jump_op2_i;

    // jalr drops bit 0 of the sum
    assign target_o = (bjp_op_i == JALR) ? {sum[XLEN-1:1], 1'b0} : sum;

    // no compressed instructions, so bit 1 set is a bad fetch
    assign misaligned_fetch_o = taken_o & target_o[1];

endmodule

/* src/exu_alu_lane.sv */
// integer ALU lane; forwarded operands see last results from before the accepting edge
`timescale 1ns/1ns

module exu_alu_lane #(
    parameter int WB_DEPTH = 2
) (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  valid_i,
    input  exu_pkg::alu_op_e      op_i,
    input  exu_pkg::data_t        op1_i,
    input  exu_pkg::data_t        op2_i,
    input  exu_pkg::operand_src_e op1_src_i,
    input  exu_pkg::operand_src_e op2_src_i,
    input  exu_pkg::reg_addr_t    rd_i,
    input  logic                  reg_we_i,
    input  exu_pkg::commit_id_t   commit_id_i,
    input  exu_pkg::data_t        lane0_last_i,
    input  exu_pkg::data_t        lane1_last_i,
    output logic                  ready_o,
    output exu_pkg::data_t        last_result_o,
    output logic                  wb_valid_o,
    output logic                  wb_we_o,
    output exu_pkg::reg_addr_t    wb_rd_o,
    output exu_pkg::data_t        wb_data_o,
    output exu_pkg::commit_id_t   wb_commit_id_o,
    input  logic                  wb_ready_i
);
    import exu_pkg::*;

    data_t      opa;
    data_t      opb;
    data_t      result;
    logic [4:0] shamt;
    logic       fifo_full;
    logic       accept;
    wb_t        push_rec;
    wb_t        pop_rec;

    function automatic data_t select_operand(operand_src_e src, data_t given,
                                             data_t last0, data_t last1);
        case (src)
            SRC_LANE0: return last0;
            SRC_LANE1: return last1;
            default:   return given;
        endcase
    endfunction

    assign opa   = select_operand(op1_src_i, op1_i, lane0_last_i, lane1_last_i);
    assign opb   = select_operand(op2_src_i, op2_i, lane0_last_i, lane1_last_i);
    assign shamt = opb[4:0];

    always_comb begin
        case (op_i)
            ADD:     result = opa + opb;
            SUB:     result = opa - opb;
            SLL:     result = opa << shamt;
            SLT:     result = data_t'($signed(opa) < $signed(opb));
            SLTU:    result = data_t'(opa < opb);
            XOR:     result = opa ^ opb;
            SRL:     result = opa >> shamt;
            SRA:     result = data_t'($signed(opa) >>> shamt);
            OR:      result = opa | opb;
            AND:     result = opa & opb;
            default: result = '0;
        endcase
    end

    // ready only reflects queue occupancy
    assign ready_o = ~fifo_full;
    assign accept  = valid_i & ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i)
            last_result_o <= '0;
        else if (accept)
            last_result_o <= result;
    end

    assign push_rec = '{we: reg_we_i, rd: rd_i, data: result, commit_id: commit_id_i};

    exu_wb_fifo #(
        .WB_DEPTH(WB_DEPTH)
    ) u_wb_fifo (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .push_i     (accept),
        .push_data_i(push_rec),
        .pop_ready_i(wb_ready_i),
        .full_o     (fifo_full),
        .pop_valid_o(wb_valid_o),
        .pop_data_o (pop_rec)
    );

    assign wb_we_o        = pop_rec.we;
    assign wb_rd_o        = pop_rec.rd;
    assign wb_data_o      = pop_rec.data;
    assign wb_commit_id_o = pop_rec.commit_id;

endmodule

/* src/exu_wb_fifo.sv */
// writeback queue; WB_DEPTH must be 2 or more, pushes while full are dropped
`timescale 1ns/1ns

module exu_wb_fifo #(
    parameter int WB_DEPTH = 2
) (
    input  logic         clk,
    input  logic         arst_n_i,
    input  logic         push_i,
    input  exu_pkg::wb_t push_data_i,
    input  logic         pop_ready_i,
    output logic         full_o,
    output logic         pop_valid_o,
    output exu_pkg::wb_t pop_data_o
);
    import exu_pkg::*;

    localparam int PTR_W = $clog2(WB_DEPTH);
    localparam int CNT_W = $clog2(WB_DEPTH + 1);

    wb_t              mem [WB_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // full depends on the count alone, no path from pop_ready_i
    assign full_o      = (count == CNT_W'(WB_DEPTH));
    assign pop_valid_o = (count != '0);
    assign pop_data_o  = mem[rd_ptr];

    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_valid_o & pop_ready_i;

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data_i;
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // depth need not be a power of two, so wrap explicitly
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(WB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* src/exu_pkg.sv */
// shared exu types; XLEN is fixed at 32 and only mtvec, mepc and mscratch exist as CSRs
package exu_pkg;

    localparam int XLEN            = 32;
    localparam int COMMIT_ID_WIDTH = 3;

    typedef logic [XLEN-1:0]            data_t;
    typedef logic [4:0]                 reg_addr_t;
    typedef logic [COMMIT_ID_WIDTH-1:0] commit_id_t;
    typedef logic [11:0]                csr_addr_t;

    // shifts take the low 5 bits of operand 2
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU,
        XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // operand comes from dispatch or from a lane's last result
    typedef enum logic [1:0] {
        SRC_OPERAND = 2'd0,
        SRC_LANE0   = 2'd1,
        SRC_LANE1   = 2'd2
    } operand_src_e;

    typedef enum logic [2:0] {
        JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU
    } bjp_op_e;

    // encoded as the low funct3 bits, 0 is not a valid access
    typedef enum logic [1:0] {
        CSRRW = 2'd1,
        CSRRS = 2'd2,
        CSRRC = 2'd3
    } csr_op_e;

    typedef struct packed {
        logic       we;
        reg_addr_t  rd;
        data_t      data;
        commit_id_t commit_id;
    } wb_t;

    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;

endpackage
